//--- common/sparc_isa_pkg.sv
package sparc_isa_pkg;

	// ----------------------------------------
	// instruction field positions
	// ----------------------------------------
	localparam int OP_MSB  = 31;
	localparam int OP_LSB  = 30;
	localparam int RD_MSB  = 29;
	localparam int RD_LSB  = 25;
	localparam int OP2_MSB = 24;   // format 2 only
	localparam int OP2_LSB = 22;
	localparam int OP3_MSB = 24;   // format 3 and ld/st
	localparam int OP3_LSB = 19;

	// ----------------------------------------
	// op field
	// ----------------------------------------
	localparam logic [1:0] FMT2    = 2'b00;   // sethi, branches
	localparam logic [1:0] CALL_OP = 2'b01;
	localparam logic [1:0] FMT3    = 2'b10;   // alu, jmpl, special regs
	localparam logic [1:0] LDST    = 2'b11;

	// format 2 subops
	localparam logic [2:0] BICC_OP  = 3'b010;
	localparam logic [2:0] SETHI_OP = 3'b100;

	// ----------------------------------------
	// op3 codes, op = 2
	// ----------------------------------------
	localparam logic [5:0] WRY   = 6'h30;   // also wrasr when rd != 0
	localparam logic [5:0] WRPSR = 6'h31;
	localparam logic [5:0] WRWIM = 6'h32;
	localparam logic [5:0] JMPL  = 6'h38;
	localparam logic [5:0] RETT  = 6'h39;
	localparam logic [5:0] TICC  = 6'h3a;

	// op3 codes, op = 3, integer loads only
	localparam logic [5:0] LD   = 6'h00;
	localparam logic [5:0] LDUB = 6'h01;
	localparam logic [5:0] LDUH = 6'h02;
	localparam logic [5:0] LDD  = 6'h03;   // even/odd pair
	localparam logic [5:0] LDSB = 6'h09;
	localparam logic [5:0] LDSH = 6'h0a;

	// trap types
	localparam logic [7:0] TT_DAEX = 8'h09;   // data_access_exception

endpackage

//--- common/iu_state_pkg.sv
package iu_state_pkg;

	typedef logic [31:0] word_t;
	typedef logic [29:0] wpc_t;   // pc without the two zero bits
	typedef logic [31:0] y_t;

	// ----------------------------------------
	// processor state register
	// ----------------------------------------
	// cwp is sized for 32 windows
	// upper bits stay 0 on smaller configs
	typedef struct packed {
		logic [3:0] icc;   // n z v c
		logic [3:0] pil;
		logic       s;     // supervisor
		logic       ps;    // previous s
		logic       et;    // traps enabled
		logic [4:0] cwp;
	} psr_t;

	// boot in supervisor mode with traps off
	localparam psr_t INIT_PSR = '{
		icc: 4'h0,
		pil: 4'h0,
		s:   1'b1,
		ps:  1'b0,
		et:  1'b0,
		cwp: 5'd0
	};

	localparam y_t INIT_Y = '0;

endpackage

//--- design/ld_align.sv
`timescale 1ns/10ps

module ld_align
	import iu_state_pkg::*;
(
	input  word_t      data,
	input  logic [3:0] byte_mask,   // bit 0 picks the msb byte
	input  logic       signext,
	output word_t      aligned
);
	logic [7:0]  sel_b;
	logic [15:0] sel_h;

	// byte lane select, big endian
	always_comb begin
		unique case (byte_mask)
		4'b0010: sel_b = data[23:16];
		4'b0100: sel_b = data[15:8];
		4'b1000: sel_b = data[7:0];
		default: sel_b = data[31:24];
		endcase
	end

	assign sel_h = byte_mask[0] ? data[31:16] : data[15:0];   // 0011 upper half

	always_comb begin
		unique case (byte_mask)
		4'b0001, 4'b0010, 4'b0100, 4'b1000:
			aligned = {{24{signext & sel_b[7]}}, sel_b};
		4'b0011, 4'b1100:
			aligned = {{16{signext & sel_h[15]}}, sel_h};
		default:
			aligned = data;   // full word or ldd
		endcase
	end

endmodule

//--- design/trap_ctrl.sv
`timescale 1ns/10ps

module trap_ctrl
	import sparc_isa_pkg::*;
	import iu_state_pkg::*;
#(
	parameter int NWIN = 8
) (
	input  word_t           inst,
	input  psr_t            psr,
	input  logic [NWIN-1:0] wim,
	input  y_t              y,
	input  word_t           ex_res,
	input  logic            run,
	input  logic            annul,
	input  logic            replay,
	input  logic            precise_trap,
	input  logic            irq_trap,
	input  logic            nodaex,
	input  logic [7:0]      tbr_tt,
	input  logic            dmmu_exception,
	input  logic            branch_true,
	output logic            trap,
	output logic [7:0]      trap_tt,
	output psr_t            next_psr,
	output logic [NWIN-1:0] next_wim,
	output y_t              next_y,
	output logic            archr_we,
	output logic            wnpc,   // npc from alu result
	output logic            rett
);
	localparam int CWP_W = $clog2(NWIN);

	logic [1:0] op;
	logic [2:0] op2;
	logic [5:0] op3;
	logic       wrpsr;
	logic       wrwim;
	logic       wry;

	assign op  = inst[OP_MSB:OP_LSB];
	assign op2 = inst[OP2_MSB:OP2_LSB];
	assign op3 = inst[OP3_MSB:OP3_LSB];

	// ----------------------------------------
	// special instruction decode
	// ----------------------------------------
	always_comb begin
		wnpc  = 1'b0;
		rett  = 1'b0;
		wrpsr = 1'b0;
		wrwim = 1'b0;
		wry   = 1'b0;
		unique case (op)
		CALL_OP: wnpc = 1'b1;
		FMT2:    wnpc = (op2 == BICC_OP) & branch_true;
		FMT3: begin
			unique case (op3)
			JMPL:  wnpc = 1'b1;
			RETT: begin
				wnpc = 1'b1;
				rett = 1'b1;
			end
			WRPSR:   wrpsr = 1'b1;
			WRWIM:   wrwim = 1'b1;
			WRY:     wry   = 1'b1;
			default: ;
			endcase
		end
		default: ;   // loads leave npc alone
		endcase
		if (annul)
			wnpc = 1'b0;   // annulled cti does not redirect
	end

	// any trap source kills the slot unless it is replayed anyway
	assign trap     = (precise_trap | irq_trap | dmmu_exception) & run & ~replay;
	assign trap_tt  = (dmmu_exception & ~nodaex) ? TT_DAEX : tbr_tt;   // daex wins
	assign archr_we = run & ~annul & ~replay;

	// ----------------------------------------
	// next psr / wim / y
	// ----------------------------------------
	always_comb begin
		next_psr = psr;
		next_wim = wim;
		next_y   = y;
		if (trap) begin
			next_psr.cwp = (psr.cwp == 5'd0) ? 5'(NWIN - 1) : psr.cwp - 5'd1;
			next_psr.et  = 1'b0;
			next_psr.ps  = psr.s;
			next_psr.s   = 1'b1;
		end else if (rett) begin
			next_psr.et = 1'b1;
			next_psr.s  = psr.ps;   // back to caller mode
		end
		if (wrpsr && !trap) begin
			next_psr.icc = ex_res[23:20];
			next_psr.pil = ex_res[11:8];
			next_psr.s   = ex_res[7];
			next_psr.ps  = ex_res[6];
			next_psr.et  = ex_res[5];
			next_psr.cwp = 5'(ex_res[CWP_W-1:0]);   // only implemented window bits
		end
		if (wrwim && !trap)
			next_wim = ex_res[NWIN-1:0];
		if (wry)
			next_y = ex_res;
	end

endmodule

//--- design/pc_gen.sv
`timescale 1ns/10ps

module pc_gen
	import iu_state_pkg::*;
(
	input  wpc_t  npc,
	input  word_t ex_res,   // jump target from the alu
	input  logic  wnpc,
	input  logic  trap,
	input  logic  run,
	input  logic  replay,
	output wpc_t  next_pc,
	output wpc_t  next_npc,
	output logic  pc_we,
	output logic  npc_we
);
	logic commit_ok;

	assign next_pc = npc;   // delayed branch
	assign next_npc = wnpc ? ex_res[31:2] : npc + 30'd1;

	// trap redirect goes out through trap_out
	assign commit_ok = run & ~replay & ~trap;
	assign pc_we     = commit_ok;
	assign npc_we    = commit_ok;

endmodule

//--- regwrite/regwrite_gen.sv
`timescale 1ns/10ps

module regwrite_gen
	import sparc_isa_pkg::*;
	import iu_state_pkg::*;
#(
	parameter int NWIN      = 8,
	parameter int REGADDR_W = 8
) (
	input  word_t                inst,
	input  wpc_t                 pc,
	input  wpc_t                 npc,
	input  word_t                ex_res,
	input  logic [63:0]          mem_res,
	input  word_t                aligned,    // upper word of mem_res, aligned
	input  psr_t                 next_psr,   // cwp after a trap
	input  logic                 trap,
	input  logic                 rett,
	input  logic                 run,
	input  logic                 annul,
	input  logic                 invalid,
	input  logic                 replay,
	input  logic                 annul_next,
	output logic [REGADDR_W-1:0] addr1,
	output logic [REGADDR_W-1:0] addr2,
	output word_t                data1,
	output word_t                data2,
	output logic                 we1,
	output logic                 we2,
	output logic                 next_annul
);
	localparam int NWREG = 16 * NWIN;   // windowed regs in the file

	logic [1:0] op;
	logic [2:0] op2;
	logic [5:0] op3;
	logic [4:0] rd;
	logic [4:0] rd1;
	logic [4:0] rd2;
	logic       wreg1;
	logic       wreg2;
	logic       ignrd;   // write even if rd is g0
	logic       slot_ok;

	// globals sit at the bottom, windows wrap modulo NWREG
	function automatic logic [REGADDR_W-1:0] win_addr(input logic [4:0] cwp,
			input logic [4:0] r);
		int idx;
		if (r < 5'd8)
			idx = int'(r);
		else
			idx = 8 + ((int'(cwp) * 16 + int'(r) - 8) % NWREG);
		return REGADDR_W'(idx);
	endfunction

	assign op  = inst[OP_MSB:OP_LSB];
	assign op2 = inst[OP2_MSB:OP2_LSB];
	assign op3 = inst[OP3_MSB:OP3_LSB];
	assign rd  = inst[RD_MSB:RD_LSB];

	// ----------------------------------------
	// destination and data select
	// ----------------------------------------
	always_comb begin
		wreg1 = 1'b0;
		wreg2 = 1'b0;
		ignrd = 1'b0;
		rd1   = rd;
		rd2   = rd;
		data1 = ex_res;    // port 1 alu result
		data2 = aligned;   // port 2 load data
		unique case (op)
		CALL_OP: begin
			wreg1 = 1'b1;
			ignrd = 1'b1;
			rd1   = 5'd15;   // %o7
			data1 = {pc, 2'b00};
		end
		FMT2: wreg1 = (op2 == SETHI_OP);
		FMT3: begin
			unique case (op3)
			JMPL: begin
				wreg1 = 1'b1;
				data1 = {pc, 2'b00};   // link address
			end
			WRY, WRPSR, WRWIM, TICC: wreg1 = 1'b0;
			default:                 wreg1 = ~rett;
			endcase
		end
		LDST: begin
			unique case (op3)
			LD, LDUB, LDUH, LDSB, LDSH: wreg2 = 1'b1;
			LDD: begin
				wreg1 = 1'b1;
				wreg2 = 1'b1;
				rd1   = {rd[4:1], 1'b1};   // odd reg gets the low word
				rd2   = {rd[4:1], 1'b0};
				data1 = mem_res[31:0];
			end
			default: ;   // stores write nothing here
			endcase
		end
		endcase
		if (trap) begin
			wreg1 = 1'b1;
			wreg2 = 1'b1;
			rd1   = 5'd17;   // %l1 of the trap window
			rd2   = 5'd18;   // %l2
			data1 = {pc, 2'b00};
			data2 = {npc, 2'b00};
		end
	end

	assign addr1 = win_addr(next_psr.cwp, rd1);
	assign addr2 = win_addr(next_psr.cwp, rd2);

	// ----------------------------------------
	// write enables
	// ----------------------------------------
	assign slot_ok = run & ~annul & ~replay & (~invalid | trap);
	assign we1     = wreg1 & ((|rd) | ignrd | trap) & slot_ok;
	assign we2     = wreg2 & ((|rd) | trap) & slot_ok;

	// idle thread keeps its annul state
	assign next_annul = run ? (annul_next & ~invalid & ~annul & ~trap) : annul;

endmodule

//--- design/commit_reg.sv
`timescale 1ns/10ps

module commit_reg
	import iu_state_pkg::*;
#(
	parameter int NWIN      = 8,
	parameter int REGADDR_W = 8
) (
	input  logic                 gclk,
	input  logic                 rst,
	input  logic [REGADDR_W-1:0] addr1,
	input  logic [REGADDR_W-1:0] addr2,
	input  word_t                data1,
	input  word_t                data2,
	input  logic                 we1,
	input  logic                 we2,
	input  wpc_t                 next_pc,
	input  wpc_t                 next_npc,
	input  logic                 next_pc_we,
	input  logic                 next_npc_we,
	input  psr_t                 next_psr,
	input  logic [NWIN-1:0]      next_wim,
	input  y_t                   next_y,
	input  logic                 next_archr_we,
	input  logic                 next_annul,
	input  logic                 trap,
	input  logic [7:0]           trap_tt,
	output logic [REGADDR_W-1:0] rf_addr1,
	output logic [REGADDR_W-1:0] rf_addr2,
	output word_t                rf_data1,
	output word_t                rf_data2,
	output logic                 rf_we1,
	output logic                 rf_we2,
	output wpc_t                 c_pc,
	output wpc_t                 c_npc,
	output logic                 pc_we,
	output logic                 npc_we,
	output psr_t                 c_psr,
	output logic [NWIN-1:0]      c_wim,
	output y_t                   c_y,
	output logic                 archr_we,
	output logic                 c_annul,
	output logic                 trap_out,
	output logic [7:0]           trap_tt_out
);

	// ----------------------------------------
	// preset on reset
	// ----------------------------------------
	always_ff @(posedge gclk) begin
		if (rst) begin
			pc_we    <= 1'b1;   // force state into the spr file
			npc_we   <= 1'b1;
			archr_we <= 1'b1;
			c_pc     <= '0;
			c_npc    <= 30'd1;
			c_psr    <= INIT_PSR;
			c_wim    <= '0;
			c_y      <= INIT_Y;
			rf_we1   <= 1'b0;
			rf_we2   <= 1'b1;   // clear g0
			rf_addr2 <= '0;
			rf_data2 <= '0;
			c_annul  <= 1'b0;
			trap_out <= 1'b0;
		end else begin
			pc_we    <= next_pc_we;
			npc_we   <= next_npc_we;
			archr_we <= next_archr_we;
			c_pc     <= next_pc;
			c_npc    <= next_npc;
			c_psr    <= next_psr;
			c_wim    <= next_wim;
			c_y      <= next_y;
			rf_we1   <= we1;
			rf_we2   <= we2;
			rf_addr2 <= addr2;
			rf_data2 <= data2;
			c_annul  <= next_annul;
			trap_out <= trap;
		end
	end

	// qualified by rf_we1 / trap_out
	always_ff @(posedge gclk) begin
		rf_addr1    <= addr1;
		rf_data1    <= data1;
		trap_tt_out <= trap_tt;
	end

endmodule

//--- design/exception_stage.sv
`timescale 1ns/10ps

module exception_stage
	import iu_state_pkg::*;
#(
	parameter  int NWIN      = 8,
	localparam int REGADDR_W = $clog2(8 + 16 * NWIN)   // globals plus windows
) (
	input  logic                 gclk,
	input  logic                 rst,
	// ----------------------------------------
	// executed instruction
	// ----------------------------------------
	input  word_t                inst,
	input  wpc_t                 pc,
	input  wpc_t                 npc,
	input  psr_t                 psr,
	input  logic [NWIN-1:0]      wim,
	input  y_t                   y,
	input  word_t                ex_res,
	input  logic [63:0]          mem_res,
	input  logic [3:0]           byte_mask,
	input  logic                 signext,
	input  logic                 run,
	input  logic                 annul,
	input  logic                 invalid,
	input  logic                 replay,
	input  logic                 precise_trap,
	input  logic                 irq_trap,
	input  logic                 nodaex,
	input  logic [7:0]           tbr_tt,
	input  logic                 dmmu_exception,
	input  logic                 branch_true,
	input  logic                 annul_next,
	// ----------------------------------------
	// commit
	// ----------------------------------------
	output logic [REGADDR_W-1:0] rf_addr1,
	output logic [REGADDR_W-1:0] rf_addr2,
	output word_t                rf_data1,
	output word_t                rf_data2,
	output logic                 rf_we1,
	output logic                 rf_we2,
	output wpc_t                 c_pc,
	output wpc_t                 c_npc,
	output logic                 pc_we,
	output logic                 npc_we,
	output psr_t                 c_psr,
	output logic [NWIN-1:0]      c_wim,
	output y_t                   c_y,
	output logic                 archr_we,
	output logic                 c_annul,
	output logic                 trap_out,
	output logic [7:0]           trap_tt_out
);
	word_t                aligned;
	logic                 trap;
	logic [7:0]           trap_tt;
	psr_t                 next_psr;
	logic [NWIN-1:0]      next_wim;
	y_t                   next_y;
	logic                 next_archr_we;
	logic                 wnpc;
	logic                 rett;
	wpc_t                 next_pc;
	wpc_t                 next_npc;
	logic                 next_pc_we;
	logic                 next_npc_we;
	logic [REGADDR_W-1:0] addr1;
	logic [REGADDR_W-1:0] addr2;
	word_t                data1;
	word_t                data2;
	logic                 we1;
	logic                 we2;
	logic                 next_annul;

	ld_align u_ld_align (
		.data      (mem_res[63:32]),   // single word loads use the upper half
		.byte_mask,
		.signext,
		.aligned
	);

	trap_ctrl #(.NWIN(NWIN)) u_trap_ctrl (
		.inst, .psr, .wim, .y, .ex_res,
		.run, .annul, .replay,
		.precise_trap, .irq_trap, .nodaex, .tbr_tt,
		.dmmu_exception, .branch_true,
		.trap, .trap_tt, .next_psr, .next_wim, .next_y,
		.archr_we  (next_archr_we),
		.wnpc, .rett
	);

	pc_gen u_pc_gen (
		.npc, .ex_res, .wnpc, .trap, .run, .replay,
		.next_pc, .next_npc,
		.pc_we     (next_pc_we),
		.npc_we    (next_npc_we)
	);

	regwrite_gen #(.NWIN(NWIN), .REGADDR_W(REGADDR_W)) u_regwrite_gen (
		.inst, .pc, .npc, .ex_res, .mem_res, .aligned, .next_psr,
		.trap, .rett, .run, .annul, .invalid, .replay, .annul_next,
		.addr1, .addr2, .data1, .data2, .we1, .we2, .next_annul
	);

	commit_reg #(.NWIN(NWIN), .REGADDR_W(REGADDR_W)) u_commit_reg (
		.gclk, .rst,
		.addr1, .addr2, .data1, .data2, .we1, .we2,
		.next_pc, .next_npc, .next_pc_we, .next_npc_we,
		.next_psr, .next_wim, .next_y, .next_archr_we,
		.next_annul, .trap, .trap_tt,
		.rf_addr1, .rf_addr2, .rf_data1, .rf_data2, .rf_we1, .rf_we2,
		.c_pc, .c_npc, .pc_we, .npc_we,
		.c_psr, .c_wim, .c_y, .archr_we,
		.c_annul, .trap_out, .trap_tt_out
	);

endmodule

//--- dv/exception_stage_checker.sv
`timescale 1ns/10ps

module exception_stage_checker
	import iu_state_pkg::*;
#(
	parameter int REGADDR_W = 8
) (
	input logic                 gclk,
	input logic                 rst,
	input logic                 trap_out,
	input psr_t                 c_psr,
	input logic                 rf_we1,
	input logic                 rf_we2,
	input logic [REGADDR_W-1:0] rf_addr1,
	input logic [REGADDR_W-1:0] rf_addr2,
	input wpc_t                 c_pc
);

	// ----------------------------------------
	// commit invariants
	// ----------------------------------------
	// trap entry always turns et off
	trap_clears_et: assert property (@(posedge gclk) disable iff (rst)
		trap_out |-> !c_psr.et)
		else $error("trap committed with traps still enabled");

	// one register file write per address per cycle
	ports_distinct: assert property (@(posedge gclk) disable iff (rst)
		(rf_we1 && rf_we2) |-> (rf_addr1 != rf_addr2))
		else $error("both register file ports write address %0d", rf_addr1);

	reset_pc_zero: assert property (@(posedge gclk)
		rst |=> (c_pc == '0))   // fetch restarts at 0
		else $error("c_pc not cleared one cycle after reset");

endmodule

//--- dv/tb_exception_stage.sv
`timescale 1ns/10ps

module tb_exception_stage
	import sparc_isa_pkg::*;
	import iu_state_pkg::*;
();
	localparam int NWIN           = 8;
	localparam int REGADDR_W      = $clog2(8 + 16 * NWIN);
	localparam int SETTLE_TIMEOUT = 20;   // cycles

	logic                 gclk;
	logic                 rst;
	word_t                inst;
	wpc_t                 pc;
	wpc_t                 npc;
	psr_t                 psr;
	logic [NWIN-1:0]      wim;
	y_t                   y;
	word_t                ex_res;
	logic [63:0]          mem_res;
	logic [3:0]           byte_mask;
	logic                 signext;
	logic                 run;
	logic                 annul;
	logic                 invalid;
	logic                 replay;
	logic                 precise_trap;
	logic                 irq_trap;
	logic                 nodaex;
	logic [7:0]           tbr_tt;
	logic                 dmmu_exception;
	logic                 branch_true;
	logic                 annul_next;
	logic [REGADDR_W-1:0] rf_addr1;
	logic [REGADDR_W-1:0] rf_addr2;
	word_t                rf_data1;
	word_t                rf_data2;
	logic                 rf_we1;
	logic                 rf_we2;
	wpc_t                 c_pc;
	wpc_t                 c_npc;
	logic                 pc_we;
	logic                 npc_we;
	psr_t                 c_psr;
	logic [NWIN-1:0]      c_wim;
	y_t                   c_y;
	logic                 archr_we;
	logic                 c_annul;
	logic                 trap_out;
	logic [7:0]           trap_tt_out;

	logic [31:0] lfsr;   // operand source
	int          checks;
	int          errors;

	exception_stage #(.NWIN(NWIN)) dut0 (.*);

	bind exception_stage exception_stage_checker #(.REGADDR_W(REGADDR_W)) chk0 (
		.gclk     (gclk),
		.rst      (rst),
		.trap_out (trap_out),
		.c_psr    (c_psr),
		.rf_we1   (rf_we1),
		.rf_we2   (rf_we2),
		.rf_addr1 (rf_addr1),
		.rf_addr2 (rf_addr2),
		.c_pc     (c_pc)
	);

	always #2 gclk = ~gclk;   // 4 ns period

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	// globals flat, windows wrap over 16*NWIN entries
	function automatic int reg_addr(input int cwp, input int r);
		if (r < 8)
			return r;
		return 8 + (cwp * 16 + r - 8) % (16 * NWIN);
	endfunction

	function automatic psr_t make_psr(input logic s, input logic ps, input logic et,
			input int cwp);
		psr_t p;
		p     = '0;
		p.s   = s;
		p.ps  = ps;
		p.et  = et;
		p.cwp = 5'(cwp);
		return p;
	endfunction

	function automatic word_t fmt3_inst(input logic [5:0] op3, input logic [4:0] rd);
		return {FMT3, rd, op3, 19'd0};
	endfunction

	function automatic word_t ld_inst(input logic [5:0] op3, input logic [4:0] rd);
		return {LDST, rd, op3, 19'd0};
	endfunction

	task automatic compare(input logic [63:0] got, input logic [63:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0d ns: %s: got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errs_before);
	endtask

	// quiet slot, run low
	task automatic idle_inputs();
		inst           = {FMT2, 5'd0, SETHI_OP, 22'd0};   // nop
		pc             = '0;
		npc            = 30'd1;
		psr            = make_psr(1'b1, 1'b0, 1'b0, 0);
		wim            = '0;
		y              = '0;
		ex_res         = '0;
		mem_res        = '0;
		byte_mask      = 4'b1111;
		signext        = 1'b0;
		run            = 1'b0;
		annul          = 1'b0;
		invalid        = 1'b0;
		replay         = 1'b0;
		precise_trap   = 1'b0;
		irq_trap       = 1'b0;
		nodaex         = 1'b0;
		tbr_tt         = '0;
		dmmu_exception = 1'b0;
		branch_true    = 1'b0;
		annul_next     = 1'b0;
	endtask

	// inputs set at a falling edge, result read at the next one
	task automatic commit_cycle();
		@(posedge gclk);
		@(negedge gclk);
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic reset_presets();
		int e0;
		int n;
		e0 = errors;
		repeat (4) @(posedge gclk);
		@(negedge gclk);
		compare(64'(c_pc), 64'd0, "reset c_pc");
		compare(64'(c_npc), 64'd1, "reset c_npc");
		compare(64'(c_psr), 64'(make_psr(1'b1, 1'b0, 1'b0, 0)), "reset c_psr");
		compare(64'(c_y), 64'd0, "reset c_y");
		compare(64'(c_wim), 64'd0, "reset c_wim");
		compare(64'({pc_we, npc_we, archr_we}), 64'd7, "reset spr enables");
		compare(64'(rf_we2), 64'd1, "reset rf_we2");
		compare(64'(rf_addr2), 64'd0, "reset rf_addr2");
		compare(64'(rf_data2), 64'd0, "reset rf_data2");
		compare(64'({rf_we1, trap_out, c_annul}), 64'd0, "reset we1/trap/annul");
		rst = 1'b0;   // run stays low
		n = 0;
		while (pc_we && n < SETTLE_TIMEOUT) begin
			commit_cycle();
			n++;
		end
		if (pc_we) begin
			errors++;
			$display("timeout: pc_we still high %0d cycles after reset release", n);
		end else
			compare(64'(n), 64'd1, "idle latency");   // one stage deep
		compare(64'({rf_we1, rf_we2, pc_we, npc_we, archr_we, trap_out}), 64'd0,
			"idle enables");
		report_test("reset_presets", e0);
	endtask

	task automatic alu_and_loads();
		int          e0;
		int          cwp;
		logic [4:0]  rd;
		logic [5:0]  op3;
		logic        sext;
		logic [31:0] w;
		logic [31:0] lo;
		logic [31:0] exp;
		logic [7:0]  b;
		logic [15:0] h;
		e0 = errors;
		for (int i = 0; i < 4; i++) begin
			cwp = int'(rand_bits(3));
			rd  = 5'(rand_bits(5)) | 5'd1;   // never g0
			w   = rand_bits(32);
			idle_inputs();
			run    = 1'b1;
			psr    = make_psr(1'b1, 1'b0, 1'b1, cwp);
			inst   = fmt3_inst(6'h00, rd);   // add
			ex_res = w;
			commit_cycle();
			compare(64'(rf_we1), 64'd1, "alu we1");
			compare(64'(rf_addr1), 64'(reg_addr(cwp, int'(rd))), "alu addr1");
			compare(64'(rf_data1), 64'(w), "alu data1");
			compare(64'(rf_we2), 64'd0, "alu we2");
		end
		idle_inputs();
		run  = 1'b1;
		inst = fmt3_inst(6'h00, 5'd0);   // rd g0 is dropped
		commit_cycle();
		compare(64'(rf_we1), 64'd0, "alu g0 we1");
		// bytes 0..3 then upper and lower half
		for (int k = 0; k < 6; k++) begin
			cwp  = int'(rand_bits(3));
			rd   = 5'(rand_bits(5)) | 5'd1;
			w    = rand_bits(32);
			sext = rand_bits(1) != 0;
			if (k < 4) begin
				b         = w[31 - 8 * k -: 8];   // big endian lane
				exp       = {{24{sext & b[7]}}, b};
				byte_mask = 4'(1 << k);
				op3       = sext ? LDSB : LDUB;
			end else begin
				h         = (k == 4) ? w[31:16] : w[15:0];
				exp       = {{16{sext & h[15]}}, h};
				byte_mask = (k == 4) ? 4'b0011 : 4'b1100;
				op3       = sext ? LDSH : LDUH;
			end
			run     = 1'b1;
			psr     = make_psr(1'b1, 1'b0, 1'b1, cwp);
			inst    = ld_inst(op3, rd);
			signext = sext;
			mem_res = {w, rand_bits(32)};
			commit_cycle();
			compare(64'(rf_we2), 64'd1, "load we2");
			compare(64'(rf_addr2), 64'(reg_addr(cwp, int'(rd))), "load addr2");
			compare(64'(rf_data2), 64'(exp), "load data2");
			compare(64'(rf_we1), 64'd0, "load we1");
			idle_inputs();
		end
		cwp = int'(rand_bits(3));
		rd  = {4'(rand_bits(4)) | 4'd1, 1'b0};   // even, not g0
		w   = rand_bits(32);
		lo  = rand_bits(32);
		run     = 1'b1;
		psr     = make_psr(1'b1, 1'b0, 1'b1, cwp);
		inst    = ld_inst(LDD, rd);
		mem_res = {w, lo};
		commit_cycle();
		compare(64'({rf_we1, rf_we2}), 64'd3, "ldd enables");
		compare(64'(rf_addr1), 64'(reg_addr(cwp, int'(rd) + 1)), "ldd odd addr");
		compare(64'(rf_data1), 64'(lo), "ldd odd data");
		compare(64'(rf_addr2), 64'(reg_addr(cwp, int'(rd))), "ldd even addr");
		compare(64'(rf_data2), 64'(w), "ldd even data");
		report_test("alu_and_loads", e0);
	endtask

	task automatic call_and_branches();
		int          e0;
		int          cwp;
		wpc_t        pc_v;
		logic [31:0] tgt;
		e0   = errors;
		cwp  = int'(rand_bits(3));
		pc_v = 30'(rand_bits(30));
		tgt  = rand_bits(32);
		idle_inputs();
		run    = 1'b1;
		psr    = make_psr(1'b1, 1'b0, 1'b1, cwp);
		pc     = pc_v;
		npc    = pc_v + 30'd1;
		ex_res = tgt;
		inst   = {CALL_OP, 30'(rand_bits(30))};
		commit_cycle();
		compare(64'(rf_we1), 64'd1, "call we1");
		compare(64'(rf_addr1), 64'(reg_addr(cwp, 15)), "call addr1 o7");
		compare(64'(rf_data1), 64'({pc_v, 2'b00}), "call link");
		compare(64'(c_pc), 64'(30'(pc_v + 30'd1)), "call c_pc");
		compare(64'(c_npc), 64'(tgt / 4), "call c_npc");
		compare(64'(npc_we), 64'd1, "call npc_we");
		for (int t = 0; t < 2; t++) begin
			pc_v = 30'(rand_bits(30));
			tgt  = rand_bits(32);
			idle_inputs();
			run         = 1'b1;
			psr         = make_psr(1'b1, 1'b0, 1'b1, cwp);
			pc          = pc_v;
			npc         = pc_v + 30'd1;
			ex_res      = tgt;
			branch_true = (t == 0);
			inst        = {FMT2, 5'b01000, BICC_OP, 22'd0};   // ba
			commit_cycle();
			compare(64'(c_pc), 64'(30'(pc_v + 30'd1)), "branch c_pc");
			if (t == 0)
				compare(64'(c_npc), 64'(tgt / 4), "taken c_npc");
			else
				compare(64'(c_npc), 64'(30'(pc_v + 30'd2)), "untaken c_npc");
			compare(64'(rf_we1), 64'd0, "branch we1");
		end
		report_test("call_and_branches", e0);
	endtask

	task automatic trap_entry();
		int         e0;
		wpc_t       pc_v;
		wpc_t       npc_v;
		logic [7:0] tt;
		psr_t       exp_psr;
		e0    = errors;
		pc_v  = 30'(rand_bits(30));
		npc_v = 30'(rand_bits(30));
		tt    = 8'(rand_bits(8)) | 8'h80;   // keep clear of daex
		idle_inputs();
		run          = 1'b1;
		psr          = make_psr(1'b0, 1'b1, 1'b1, 0);   // user mode, cwp 0
		psr.icc      = 4'h5;
		psr.pil      = 4'h3;
		pc           = pc_v;
		npc          = npc_v;
		inst         = fmt3_inst(6'h00, 5'd3);
		precise_trap = 1'b1;
		tbr_tt       = tt;
		commit_cycle();
		exp_psr     = make_psr(1'b1, 1'b0, 1'b0, NWIN - 1);   // wrapped window
		exp_psr.icc = 4'h5;
		exp_psr.pil = 4'h3;
		compare(64'(c_psr), 64'(exp_psr), "trap c_psr");
		compare(64'(trap_out), 64'd1, "trap_out");
		compare(64'(trap_tt_out), 64'(tt), "trap tt");
		compare(64'({pc_we, npc_we}), 64'd0, "trap pc enables");
		compare(64'({rf_we1, rf_we2}), 64'd3, "trap rf enables");
		compare(64'(rf_addr1), 64'(reg_addr(NWIN - 1, 17)), "trap l1 addr");
		compare(64'(rf_data1), 64'({pc_v, 2'b00}), "trap l1 pc");
		compare(64'(rf_addr2), 64'(reg_addr(NWIN - 1, 18)), "trap l2 addr");
		compare(64'(rf_data2), 64'({npc_v, 2'b00}), "trap l2 npc");
		for (int n = 0; n < 2; n++) begin
			idle_inputs();
			run            = 1'b1;
			psr            = make_psr(1'b1, 1'b0, 1'b1, 2);
			dmmu_exception = 1'b1;
			nodaex         = (n == 1);
			tbr_tt         = tt;
			commit_cycle();
			compare(64'(trap_out), 64'd1, "dmmu trap_out");
			compare(64'(trap_tt_out), (n == 1) ? 64'(tt) : 64'(TT_DAEX), "dmmu tt");
		end
		report_test("trap_entry", e0);
	endtask

	task automatic special_regs();
		int          e0;
		int          cwp;
		logic [31:0] res;
		psr_t        exp_psr;
		e0  = errors;
		cwp = int'(rand_bits(3));
		res = rand_bits(32);
		idle_inputs();
		run    = 1'b1;
		psr    = make_psr(1'b1, 1'b0, 1'b1, cwp);
		inst   = fmt3_inst(WRPSR, 5'd9);   // rd field is ignored
		ex_res = res;
		commit_cycle();
		exp_psr     = make_psr(res[7], res[6], res[5], int'(res[4:0]) % NWIN);
		exp_psr.icc = res[23:20];
		exp_psr.pil = res[11:8];
		compare(64'(c_psr), 64'(exp_psr), "wrpsr c_psr");
		compare(64'(archr_we), 64'd1, "wrpsr archr_we");
		compare(64'(rf_we1), 64'd0, "wrpsr we1");
		res  = rand_bits(32);
		inst = fmt3_inst(WRWIM, 5'd0);
		ex_res = res;
		commit_cycle();
		compare(64'(c_wim), 64'(res[NWIN-1:0]), "wrwim c_wim");
		compare(64'(archr_we), 64'd1, "wrwim archr_we");
		res  = rand_bits(32);
		inst = fmt3_inst(WRY, 5'd0);
		ex_res = res;
		commit_cycle();
		compare(64'(c_y), 64'(res), "wry c_y");
		// rett from a user caller
		res  = rand_bits(32);
		psr  = make_psr(1'b1, 1'b0, 1'b0, cwp);
		inst = fmt3_inst(RETT, 5'd17);
		ex_res = res;
		commit_cycle();
		compare(64'(c_psr), 64'(make_psr(1'b0, 1'b0, 1'b1, cwp)), "rett c_psr");
		compare(64'(c_npc), 64'(res / 4), "rett c_npc");
		compare(64'(rf_we1), 64'd0, "rett we1");
		report_test("special_regs", e0);
	endtask

	task automatic replay_and_annul();
		int e0;
		e0 = errors;
		idle_inputs();
		run          = 1'b1;
		replay       = 1'b1;
		precise_trap = 1'b1;   // replay wins over the trap
		psr          = make_psr(1'b1, 1'b0, 1'b1, 4);
		inst         = fmt3_inst(6'h00, 5'd9);
		commit_cycle();
		compare(64'({rf_we1, rf_we2}), 64'd0, "replay rf enables");
		compare(64'({pc_we, npc_we, archr_we}), 64'd0, "replay spr enables");
		compare(64'(trap_out), 64'd0, "replay trap_out");
		for (int m = 0; m < 3; m++) begin
			idle_inputs();
			run          = 1'b1;
			annul_next   = 1'b1;
			invalid      = (m == 1);
			precise_trap = (m == 2);
			commit_cycle();
			compare(64'(c_annul), (m == 0) ? 64'd1 : 64'd0, "c_annul");
		end
		report_test("replay_and_annul", e0);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		gclk   = 1'b0;
		rst    = 1'b1;
		lfsr   = 32'd70;
		checks = 0;
		errors = 0;
		idle_inputs();
		reset_presets();
		alu_and_loads();
		call_and_branches();
		trap_entry();
		special_regs();
		replay_and_annul();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- files.f
common/sparc_isa_pkg.sv
common/iu_state_pkg.sv
design/ld_align.sv
design/trap_ctrl.sv
design/pc_gen.sv
regwrite/regwrite_gen.sv
design/commit_reg.sv
design/exception_stage.sv
dv/exception_stage_checker.sv
dv/tb_exception_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the exception stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
	--top-module tb_exception_stage \
	-f files.f \
	-Mdir obj_dir -o sim_exception_stage

if ! ./obj_dir/sim_exception_stage > sim.log 2>&1; then
	cat sim.log
	echo "simulator exited with an error"
	exit 1
fi
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
